//--- design/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

	localparam int xlen    = 32; // data path width
	localparam int raddr_w = 5;  // gpr index width

	localparam logic [xlen-1:0] reset_pc = 32'h1c000000; // first fetch

	// major/minor opcode fields, compared against the matching format view
	localparam logic [16:0] op_add_w   = 17'b00000000000100000;
	localparam logic [16:0] op_sub_w   = 17'b00000000000100010;
	localparam logic [9:0]  op_addi_w  = 10'b0000001010;
	localparam logic [6:0]  op_lu12i_w = 7'b0001010;
	localparam logic [9:0]  op_ld_w    = 10'b0010100010;
	localparam logic [9:0]  op_st_w    = 10'b0010100110;
	localparam logic [5:0]  op_beq     = 6'b010110;
	localparam logic [5:0]  op_bne     = 6'b010111;
	localparam logic [5:0]  op_b       = 6'b010100;

	// one instruction word, four encodings
	typedef union packed {
		struct packed {
			logic [16:0] op;
			logic [4:0]  rk;
			logic [4:0]  rj;
			logic [4:0]  rd;
		} r3;
		struct packed {
			logic [9:0]  op;
			logic [11:0] si12;
			logic [4:0]  rj;
			logic [4:0]  rd;
		} ri12;
		struct packed {
			logic [6:0]  op;
			logic [19:0] si20;
			logic [4:0]  rd;
		} ri20;
		struct packed {
			logic [5:0]  op;
			logic [15:0] offs16; // low part of offs26 for b
			logic [4:0]  rj;     // rj/rd carry offs26[25:16] for b
			logic [4:0]  rd;
		} ri16;
	} inst_word_u;

	typedef enum logic [1:0] {
		alu_add,
		alu_sub,
		alu_lui // pass src2 through
	} alu_op_e;

	typedef enum logic [1:0] {
		br_none,
		br_beq,
		br_bne,
		br_b
	} br_kind_e;

	typedef struct packed {
		logic [xlen-1:0] pc;
		inst_word_u      inst;
	} if_id_t;

	typedef struct packed {
		logic [xlen-1:0]    pc;
		logic [xlen-1:0]    src1;    // rj value
		logic [xlen-1:0]    src2;    // rk/rd value or immediate
		logic [xlen-1:0]    st_data; // rd value for st.w
		logic [xlen-1:0]    imm;     // also the branch offset
		alu_op_e            alu_op;
		logic [raddr_w-1:0] dest;
		logic               gpr_we;
		logic               is_load;
		logic               is_store;
		br_kind_e           br_kind;
	} id_ex_t;

	typedef struct packed {
		logic [xlen-1:0]    pc;
		logic [xlen-1:0]    result; // alu value or memory address
		logic [xlen-1:0]    st_data;
		logic [raddr_w-1:0] dest;
		logic               gpr_we;
		logic               is_load;
		logic               is_store;
	} ex_mem_t;

	typedef struct packed {
		logic               we;      // already qualified by stage valid
		logic [raddr_w-1:0] dest;
		logic               is_load;
		logic [xlen-1:0]    result;
	} bypass_t;

	typedef struct packed {
		logic               we;
		logic [raddr_w-1:0] addr;
		logic [xlen-1:0]    data;
	} wb_write_t;

endpackage

`default_nettype wire

//--- design/pipe_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module pipe_ctrl (
	input  logic       clk,
	input  logic       reset,
	input  logic       id_hazard,   // load-use stall in ID
	input  logic       br_taken,    // taken branch resolved in EX
	output logic [4:0] pipe_valid,  // 0 IF, 1 ID, 2 EX, 3 MEM, 4 WB
	output logic [4:0] allowin,
	output logic [3:0] tonext_valid
);

	logic [4:0] ready_go;

	// only ID can hold, everything else goes once valid
	assign ready_go = {pipe_valid[4:2], pipe_valid[1] & ~id_hazard, pipe_valid[0]};

	// allowin chain, computed from WB back to IF
	always_comb begin
		allowin[4] = ~pipe_valid[4] | ready_go[4]; // WB never holds
		allowin[3] = ~pipe_valid[3] | ready_go[3] & allowin[4];
		allowin[2] = ~pipe_valid[2] | ready_go[2] & allowin[3];
		// a flushed ID slot frees up even while stalled,
		// so the target fetch is never blocked
		allowin[1] = ~pipe_valid[1] | ready_go[1] & allowin[2] | br_taken;
		allowin[0] = ~pipe_valid[0] | ready_go[0] & allowin[1];
	end

	assign tonext_valid = allowin[4:1] & ready_go[3:0];

	always_ff @(posedge clk) begin
		if (reset) begin
			pipe_valid <= '0;
		end else begin
			if (allowin[0])
				pipe_valid[0] <= 1'b1; // a fetch went out
			if (br_taken)
				pipe_valid[1] <= 1'b0; // wrong-path instr killed
			else if (allowin[1])
				pipe_valid[1] <= tonext_valid[0];
			if (br_taken) begin
				if (tonext_valid[2])
					pipe_valid[2] <= 1'b0; // branch left, nothing behind it
			end else if (allowin[2]) begin
				pipe_valid[2] <= tonext_valid[1]; // bubble on stall
			end
			if (allowin[3])
				pipe_valid[3] <= tonext_valid[2];
			if (allowin[4])
				pipe_valid[4] <= tonext_valid[3];
		end
	end

endmodule

`default_nettype wire

//--- design/fetch_stage.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_stage (
	input  logic                     clk,
	input  logic                     reset,
	input  logic                     allowin_if,
	input  logic                     br_taken,
	input  logic [cpu_pkg::xlen-1:0] br_target,
	input  logic [cpu_pkg::xlen-1:0] inst_sram_rdata,
	output logic                     inst_sram_en,
	output logic [cpu_pkg::xlen-1:0] inst_sram_addr,
	output cpu_pkg::if_id_t          if_id
);
	import cpu_pkg::*;

	logic [xlen-1:0] pc;      // pc of the word now on rdata
	logic [xlen-1:0] next_pc;

	assign next_pc = br_taken ? br_target : pc + 32'd4;

	// sram keeps rdata while en is low, so a held IF keeps its word
	assign inst_sram_en   = allowin_if;
	assign inst_sram_addr = next_pc;

	always_ff @(posedge clk) begin
		if (reset)
			pc <= reset_pc - 32'd4; // first next_pc lands on reset_pc
		else if (allowin_if)
			pc <= next_pc;
	end

	assign if_id.pc   = pc;
	assign if_id.inst = inst_sram_rdata;

endmodule

`default_nettype wire

//--- design/decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 load_id,  // IF tonext_valid
	input  cpu_pkg::if_id_t      if_id,
	input  cpu_pkg::bypass_t     ex_byp,
	input  cpu_pkg::bypass_t     mem_byp,
	input  cpu_pkg::bypass_t     wb_byp,
	input  cpu_pkg::wb_write_t   wb_write,
	output logic                 id_hazard,
	output cpu_pkg::id_ex_t      id_ex
);
	import cpu_pkg::*;

	if_id_t             id_r;
	inst_word_u         inst;
	logic [xlen-1:0]    rf [32];
	logic               is_add;
	logic               is_sub;
	logic               is_addi;
	logic               is_lu12i;
	logic               is_ld;
	logic               is_st;
	logic               is_beq;
	logic               is_bne;
	logic               is_b;
	logic [raddr_w-1:0] raddr1;
	logic [raddr_w-1:0] raddr2;
	logic               ren1;
	logic               ren2;
	logic [xlen-1:0]    imm;
	logic [xlen-1:0]    rdata1;
	logic [xlen-1:0]    rdata2;
	logic [xlen-1:0]    val1;
	logic [xlen-1:0]    val2;

	// youngest producer wins, r0 always zero
	function automatic logic [xlen-1:0] read_src(input logic [raddr_w-1:0] a,
			input logic [xlen-1:0] rf_val, input bypass_t e, input bypass_t m,
			input bypass_t w);
		if (a == '0)
			return '0;
		else if (e.we && e.dest == a)
			return e.result;
		else if (m.we && m.dest == a)
			return m.result;
		else if (w.we && w.dest == a)
			return w.result;
		return rf_val;
	endfunction

	// load still in flight, no data yet
	function automatic logic load_hit(input logic [raddr_w-1:0] a, input bypass_t b);
		return b.we && b.is_load && b.dest == a;
	endfunction

	always_ff @(posedge clk) begin
		if (reset)
			id_r <= '0; // all-zero word decodes as a nop
		else if (load_id)
			id_r <= if_id;
	end

	always_ff @(posedge clk) begin
		if (wb_write.we)
			rf[wb_write.addr] <= wb_write.data;
	end

	assign inst     = id_r.inst;
	assign is_add   = inst.r3.op == op_add_w;
	assign is_sub   = inst.r3.op == op_sub_w;
	assign is_addi  = inst.ri12.op == op_addi_w;
	assign is_lu12i = inst.ri20.op == op_lu12i_w;
	assign is_ld    = inst.ri12.op == op_ld_w;
	assign is_st    = inst.ri12.op == op_st_w;
	assign is_beq   = inst.ri16.op == op_beq;
	assign is_bne   = inst.ri16.op == op_bne;
	assign is_b     = inst.ri16.op == op_b;

	assign raddr1 = inst.r3.rj;
	assign raddr2 = (is_add | is_sub) ? inst.r3.rk : inst.r3.rd; // rd for st/beq/bne
	assign ren1   = is_add | is_sub | is_addi | is_ld | is_st | is_beq | is_bne;
	assign ren2   = is_add | is_sub | is_st | is_beq | is_bne;

	always_comb begin
		if (is_lu12i)
			imm = {inst.ri20.si20, 12'b0};
		else if (is_b)
			imm = {{4{inst.ri16.rj[4]}}, inst.ri16.rj, inst.ri16.rd, inst.ri16.offs16, 2'b00};
		else if (is_beq | is_bne)
			imm = {{14{inst.ri16.offs16[15]}}, inst.ri16.offs16, 2'b00};
		else
			imm = {{20{inst.ri12.si12[11]}}, inst.ri12.si12}; // addi/ld/st
	end

	// write-first, covers the WB write of this cycle
	assign rdata1 = (wb_write.we && wb_write.addr == raddr1) ? wb_write.data : rf[raddr1];
	assign rdata2 = (wb_write.we && wb_write.addr == raddr2) ? wb_write.data : rf[raddr2];

	assign val1 = read_src(raddr1, rdata1, ex_byp, mem_byp, wb_byp);
	assign val2 = read_src(raddr2, rdata2, ex_byp, mem_byp, wb_byp);

	// load in EX or MEM holds ID, WB is forwarded
	assign id_hazard = ren1 && raddr1 != '0
			&& (load_hit(raddr1, ex_byp) || load_hit(raddr1, mem_byp))
		|| ren2 && raddr2 != '0
			&& (load_hit(raddr2, ex_byp) || load_hit(raddr2, mem_byp));

	always_comb begin
		id_ex.pc       = id_r.pc;
		id_ex.src1     = val1;
		id_ex.src2     = (is_addi | is_lu12i | is_ld | is_st) ? imm : val2;
		id_ex.st_data  = val2;
		id_ex.imm      = imm;
		id_ex.alu_op   = is_sub ? alu_sub : is_lu12i ? alu_lui : alu_add;
		id_ex.dest     = inst.r3.rd;
		id_ex.gpr_we   = is_add | is_sub | is_addi | is_lu12i | is_ld;
		id_ex.is_load  = is_ld;
		id_ex.is_store = is_st;
		id_ex.br_kind  = is_beq ? br_beq : is_bne ? br_bne : is_b ? br_b : br_none;
	end

endmodule

`default_nettype wire

//--- design/execute_stage.sv
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
	input  logic                     clk,
	input  logic                     reset,
	input  logic                     load_ex,  // ID tonext_valid
	input  logic                     valid_ex,
	input  cpu_pkg::id_ex_t          id_ex,
	output logic                     br_taken,
	output logic [cpu_pkg::xlen-1:0] br_target,
	output cpu_pkg::bypass_t         ex_byp,
	output cpu_pkg::ex_mem_t         ex_mem
);
	import cpu_pkg::*;

	id_ex_t          ex_r;
	logic [xlen-1:0] alu_res; // address for ld/st
	logic            br_cond;

	always_ff @(posedge clk) begin
		if (reset)
			ex_r <= '0;
		else if (load_ex)
			ex_r <= id_ex;
	end

	always_comb begin
		case (ex_r.alu_op)
			alu_sub: alu_res = ex_r.src1 - ex_r.src2;
			alu_lui: alu_res = ex_r.src2; // lu12i, imm already shifted
			default: alu_res = ex_r.src1 + ex_r.src2;
		endcase
	end

	always_comb begin
		case (ex_r.br_kind)
			br_beq:  br_cond = ex_r.src1 == ex_r.src2;
			br_bne:  br_cond = ex_r.src1 != ex_r.src2;
			br_b:    br_cond = 1'b1;
			default: br_cond = 1'b0;
		endcase
	end

	assign br_taken  = valid_ex & br_cond; // one cycle, EX always moves on
	assign br_target = ex_r.pc + ex_r.imm;

	assign ex_byp.we      = valid_ex & ex_r.gpr_we;
	assign ex_byp.dest    = ex_r.dest;
	assign ex_byp.is_load = ex_r.is_load;
	assign ex_byp.result  = alu_res;

	assign ex_mem.pc       = ex_r.pc;
	assign ex_mem.result   = alu_res;
	assign ex_mem.st_data  = ex_r.st_data;
	assign ex_mem.dest     = ex_r.dest;
	assign ex_mem.gpr_we   = ex_r.gpr_we;
	assign ex_mem.is_load  = ex_r.is_load;
	assign ex_mem.is_store = ex_r.is_store;

endmodule

`default_nettype wire

//--- design/mem_wb_stage.sv
`timescale 1ns/1ps
`default_nettype none

module mem_wb_stage (
	input  logic                        clk,
	input  logic                        reset,
	input  logic                        load_mem, // EX tonext_valid
	input  logic                        load_wb,  // MEM tonext_valid
	input  logic                        valid_mem,
	input  logic                        valid_wb,
	input  cpu_pkg::ex_mem_t            ex_mem,
	input  logic [cpu_pkg::xlen-1:0]    data_sram_rdata,
	output logic                        data_sram_en,
	output logic [3:0]                  data_sram_we,
	output logic [cpu_pkg::xlen-1:0]    data_sram_addr,
	output logic [cpu_pkg::xlen-1:0]    data_sram_wdata,
	output cpu_pkg::bypass_t            mem_byp,
	output cpu_pkg::bypass_t            wb_byp,
	output cpu_pkg::wb_write_t          wb_write,
	output logic [cpu_pkg::xlen-1:0]    debug_wb_pc,
	output logic                        debug_wb_rf_we,
	output logic [cpu_pkg::raddr_w-1:0] debug_wb_rf_wnum,
	output logic [cpu_pkg::xlen-1:0]    debug_wb_rf_wdata
);
	import cpu_pkg::*;

	ex_mem_t         mem_r;
	ex_mem_t         wb_r;
	logic [xlen-1:0] wb_data;

	always_ff @(posedge clk) begin
		if (reset) begin
			mem_r <= '0;
			wb_r  <= '0;
		end else begin
			if (load_mem)
				mem_r <= ex_mem;
			if (load_wb)
				wb_r <= mem_r;
		end
	end

	// word access only, store writes all four bytes
	assign data_sram_en    = valid_mem & (mem_r.is_load | mem_r.is_store);
	assign data_sram_we    = {4{valid_mem & mem_r.is_store}};
	assign data_sram_addr  = mem_r.result;
	assign data_sram_wdata = mem_r.st_data;

	assign mem_byp.we      = valid_mem & mem_r.gpr_we;
	assign mem_byp.dest    = mem_r.dest;
	assign mem_byp.is_load = mem_r.is_load; // data not back yet
	assign mem_byp.result  = mem_r.result;

	// MEM always moves, so rdata lines up with WB
	assign wb_data = wb_r.is_load ? data_sram_rdata : wb_r.result;

	assign wb_byp.we      = valid_wb & wb_r.gpr_we;
	assign wb_byp.dest    = wb_r.dest;
	assign wb_byp.is_load = wb_r.is_load;
	assign wb_byp.result  = wb_data;

	assign wb_write.we   = valid_wb & wb_r.gpr_we & (wb_r.dest != '0); // r0 dropped
	assign wb_write.addr = wb_r.dest;
	assign wb_write.data = wb_data;

	assign debug_wb_pc       = wb_r.pc;
	assign debug_wb_rf_we    = wb_write.we;
	assign debug_wb_rf_wnum  = wb_write.addr;
	assign debug_wb_rf_wdata = wb_write.data;

endmodule

`default_nettype wire

//--- design/cpu_top.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_top (
	input  logic                        clk,
	input  logic                        reset,
	output logic                        inst_sram_en,
	output logic [cpu_pkg::xlen-1:0]    inst_sram_addr,
	input  logic [cpu_pkg::xlen-1:0]    inst_sram_rdata,
	output logic                        data_sram_en,
	output logic [3:0]                  data_sram_we,
	output logic [cpu_pkg::xlen-1:0]    data_sram_addr,
	output logic [cpu_pkg::xlen-1:0]    data_sram_wdata,
	input  logic [cpu_pkg::xlen-1:0]    data_sram_rdata,
	output logic [cpu_pkg::xlen-1:0]    debug_wb_pc,
	output logic                        debug_wb_rf_we,
	output logic [cpu_pkg::raddr_w-1:0] debug_wb_rf_wnum,
	output logic [cpu_pkg::xlen-1:0]    debug_wb_rf_wdata
);
	import cpu_pkg::*;

	logic [4:0]      pipe_valid;   // 0 IF .. 4 WB
	logic [4:0]      allowin;
	logic [3:0]      tonext_valid;
	logic            id_hazard;
	logic            br_taken;
	logic [xlen-1:0] br_target;
	if_id_t          if_id;
	id_ex_t          id_ex;
	ex_mem_t         ex_mem;
	bypass_t         ex_byp;
	bypass_t         mem_byp;
	bypass_t         wb_byp;
	wb_write_t       wb_write;

	pipe_ctrl u_ctrl (
		.clk          (clk),
		.reset        (reset),
		.id_hazard    (id_hazard),
		.br_taken     (br_taken),
		.pipe_valid   (pipe_valid),
		.allowin      (allowin),
		.tonext_valid (tonext_valid)
	);

	fetch_stage u_fetch (
		.clk             (clk),
		.reset           (reset),
		.allowin_if      (allowin[0]),
		.br_taken        (br_taken),
		.br_target       (br_target),
		.inst_sram_rdata (inst_sram_rdata),
		.inst_sram_en    (inst_sram_en),
		.inst_sram_addr  (inst_sram_addr),
		.if_id           (if_id)
	);

	decode_stage u_decode (
		.clk       (clk),
		.reset     (reset),
		.load_id   (tonext_valid[0]),
		.if_id     (if_id),
		.ex_byp    (ex_byp),
		.mem_byp   (mem_byp),
		.wb_byp    (wb_byp),
		.wb_write  (wb_write),
		.id_hazard (id_hazard),
		.id_ex     (id_ex)
	);

	execute_stage u_execute (
		.clk       (clk),
		.reset     (reset),
		.load_ex   (tonext_valid[1]),
		.valid_ex  (pipe_valid[2]),
		.id_ex     (id_ex),
		.br_taken  (br_taken),
		.br_target (br_target),
		.ex_byp    (ex_byp),
		.ex_mem    (ex_mem)
	);

	mem_wb_stage u_mem_wb (
		.clk               (clk),
		.reset             (reset),
		.load_mem          (tonext_valid[2]),
		.load_wb           (tonext_valid[3]),
		.valid_mem         (pipe_valid[3]),
		.valid_wb          (pipe_valid[4]),
		.ex_mem            (ex_mem),
		.data_sram_rdata   (data_sram_rdata),
		.data_sram_en      (data_sram_en),
		.data_sram_we      (data_sram_we),
		.data_sram_addr    (data_sram_addr),
		.data_sram_wdata   (data_sram_wdata),
		.mem_byp           (mem_byp),
		.wb_byp            (wb_byp),
		.wb_write          (wb_write),
		.debug_wb_pc       (debug_wb_pc),
		.debug_wb_rf_we    (debug_wb_rf_we),
		.debug_wb_rf_wnum  (debug_wb_rf_wnum),
		.debug_wb_rf_wdata (debug_wb_rf_wdata)
	);

endmodule

`default_nettype wire

//--- sim/tb_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module tb_assertions (
	input logic                     clk,
	input logic                     reset,
	input logic [cpu_pkg::xlen-1:0] inst_sram_addr,
	input logic                     data_sram_en,
	input logic [3:0]               data_sram_we,
	input logic [cpu_pkg::xlen-1:0] data_sram_addr,
	input logic                     debug_wb_rf_we
);

	int fails = 0; // failed assertions so far

	fetch_aligned: assert property (@(posedge clk) disable iff (reset)
			inst_sram_addr[1:0] == 2'b00)
		else begin
			$error("fetch address %h not word aligned", inst_sram_addr);
			fails++;
		end

	// aligned word access with all four byte strobes on a store
	data_word_access: assert property (@(posedge clk) disable iff (reset)
			data_sram_en |-> data_sram_addr[1:0] == 2'b00
				&& (data_sram_we == 4'b0000 || data_sram_we == 4'b1111))
		else begin
			$error("bad data sram access at %h with strobes %b", data_sram_addr,
					data_sram_we);
			fails++;
		end

	no_trace_after_reset: assert property (@(posedge clk)
			reset |=> !debug_wb_rf_we)
		else begin
			$error("register write traced right after reset");
			fails++;
		end

endmodule

`default_nettype wire

//--- sim/tb_checker.sv
`timescale 1ns/1ps
`default_nettype none

module tb_checker #(
	parameter int depth = 64
) (
	input  logic                        clk,
	input  logic                        reset,
	input  logic [cpu_pkg::xlen-1:0]    debug_wb_pc,
	input  logic                        debug_wb_rf_we,
	input  logic [cpu_pkg::raddr_w-1:0] debug_wb_rf_wnum,
	input  logic [cpu_pkg::xlen-1:0]    debug_wb_rf_wdata,
	input  int                          num_exp,
	input  logic [cpu_pkg::xlen-1:0]    exp_pc [depth],
	input  logic [cpu_pkg::raddr_w-1:0] exp_num [depth],
	input  logic [cpu_pkg::xlen-1:0]    exp_data [depth],
	output int                          seen,
	output int                          mismatches,
	output int                          extra
);
	import cpu_pkg::*;

	task automatic compare_field(input string name, input logic [xlen-1:0] expected,
			input logic [xlen-1:0] actual);
		if (expected !== actual) begin
			$display("Fail time=%0t %s expected %h got %h", $time, name, expected, actual);
			mismatches++;
		end
	endtask

	// mid-cycle sample, trace outputs settled by now
	always @(negedge clk) begin
		if (reset) begin
			seen       = 0;
			mismatches = 0;
			extra      = 0;
		end else if (debug_wb_rf_we) begin
			if (seen < num_exp) begin // next entry in program order
				compare_field("debug_wb_pc", exp_pc[seen], debug_wb_pc);
				compare_field("debug_wb_rf_wnum", 32'(exp_num[seen]), 32'(debug_wb_rf_wnum));
				compare_field("debug_wb_rf_wdata", exp_data[seen], debug_wb_rf_wdata);
				seen++;
			end else begin
				$display("unexpected register write at %0t: r%0d <= %h from pc %h",
						$time, debug_wb_rf_wnum, debug_wb_rf_wdata, debug_wb_pc);
				extra++;
			end
		end
	end

endmodule

`default_nettype wire

//--- sim/tb_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_top;
	import cpu_pkg::*;

	localparam int max_words = 512; // capacity of the data file image
	localparam int max_trace = 64;
	localparam int mem_words = 256; // words per sram, indexed by addr[9:2]

	logic                clk;
	logic                reset;
	logic                inst_sram_en;
	logic [xlen-1:0]     inst_sram_addr;
	logic [xlen-1:0]     inst_sram_rdata;
	logic                data_sram_en;
	logic [3:0]          data_sram_we;
	logic [xlen-1:0]     data_sram_addr;
	logic [xlen-1:0]     data_sram_wdata;
	logic [xlen-1:0]     data_sram_rdata;
	logic [xlen-1:0]     debug_wb_pc;
	logic                debug_wb_rf_we;
	logic [raddr_w-1:0]  debug_wb_rf_wnum;
	logic [xlen-1:0]     debug_wb_rf_wdata;

	logic [xlen-1:0]     input_mem [max_words]; // raw file image
	logic [xlen-1:0]     imem [mem_words];
	logic [xlen-1:0]     dmem [mem_words];
	logic [xlen-1:0]     exp_pc [max_trace];
	logic [raddr_w-1:0]  exp_num [max_trace];
	logic [xlen-1:0]     exp_data [max_trace];
	int                  n_prog;      // program words
	int                  n_exp;       // expected trace entries
	int                  seen;        // matched trace entries so far
	int                  mismatches;
	int                  extra;
	logic                loaded;
	logic                input_ok;

	cpu_top DUT (
		.clk               (clk),
		.reset             (reset),
		.inst_sram_en      (inst_sram_en),
		.inst_sram_addr    (inst_sram_addr),
		.inst_sram_rdata   (inst_sram_rdata),
		.data_sram_en      (data_sram_en),
		.data_sram_we      (data_sram_we),
		.data_sram_addr    (data_sram_addr),
		.data_sram_wdata   (data_sram_wdata),
		.data_sram_rdata   (data_sram_rdata),
		.debug_wb_pc       (debug_wb_pc),
		.debug_wb_rf_we    (debug_wb_rf_we),
		.debug_wb_rf_wnum  (debug_wb_rf_wnum),
		.debug_wb_rf_wdata (debug_wb_rf_wdata)
	);

	tb_checker #(.depth(max_trace)) u_checker (
		.clk               (clk),
		.reset             (reset),
		.debug_wb_pc       (debug_wb_pc),
		.debug_wb_rf_we    (debug_wb_rf_we),
		.debug_wb_rf_wnum  (debug_wb_rf_wnum),
		.debug_wb_rf_wdata (debug_wb_rf_wdata),
		.num_exp           (n_exp),
		.exp_pc            (exp_pc),
		.exp_num           (exp_num),
		.exp_data          (exp_data),
		.seen              (seen),
		.mismatches        (mismatches),
		.extra             (extra)
	);

	bind cpu_top tb_assertions u_assertions (
		.clk            (clk),
		.reset          (reset),
		.inst_sram_addr (inst_sram_addr),
		.data_sram_en   (data_sram_en),
		.data_sram_we   (data_sram_we),
		.data_sram_addr (data_sram_addr),
		.debug_wb_rf_we (debug_wb_rf_we)
	);

	// file holds counts, program words, then pc/reg/value triples
	task automatic load_input();
		int base;
		$readmemh("sim/cpu_input.txt", input_mem);
		n_prog   = input_mem[0];
		n_exp    = input_mem[1];
		input_ok = n_prog > 0 && n_prog <= mem_words && n_exp > 0 && n_exp <= max_trace
				&& 2 + n_prog + 3 * n_exp <= max_words;
		if (input_ok) begin
			for (int i = 0; i < mem_words; i++)
				imem[i] = '0; // zero word decodes as a nop
			for (int i = 0; i < n_prog; i++)
				imem[i] = input_mem[2 + i];
			base = 2 + n_prog;
			for (int k = 0; k < n_exp; k++) begin
				exp_pc[k]   = input_mem[base + 3 * k];
				exp_num[k]  = input_mem[base + 3 * k + 1][raddr_w-1:0];
				exp_data[k] = input_mem[base + 3 * k + 2];
			end
		end
	endtask

	task automatic print_counts(input int missing);
		$display("errors: mismatches=%0d missing=%0d extra=%0d assertions=%0d",
				mismatches, missing, extra, DUT.u_assertions.fails);
	endtask

	// fetch runs well past the last word, so every real instr has retired
	task automatic wait_past_program(input logic [xlen-1:0] end_addr);
		do
			@(negedge clk);
		while (inst_sram_addr < end_addr);
	endtask

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// word shows up 1 ns after the edge and holds while en is low
	always @(posedge clk) begin : imem_port
		logic [xlen-1:0] word;
		logic            hit;
		hit  = inst_sram_en;
		word = imem[inst_sram_addr[9:2]];
		#1;
		if (hit)
			inst_sram_rdata = word;
	end

	// byte writes land at the edge and rdata returns the old word
	always @(posedge clk) begin : dmem_port
		logic [xlen-1:0] word;
		logic            hit;
		logic [7:0]      idx;
		idx  = data_sram_addr[9:2];
		hit  = data_sram_en;
		word = dmem[idx];
		if (hit)
			for (int b = 0; b < 4; b++)
				if (data_sram_we[b])
					dmem[idx][8*b +: 8] = data_sram_wdata[8*b +: 8];
		#1;
		if (hit)
			data_sram_rdata = word;
	end

	initial begin : watchdog
		int limit;
		wait (loaded);
		limit = n_exp * 10 + 100; // cycles scaled by trace length
		repeat (limit) @(posedge clk);
		$display("watchdog expired after %0d cycles, %0d of %0d register writes seen",
				limit, seen, n_exp);
		print_counts(n_exp - seen);
		$display("Test failed");
		$finish;
	end

	initial begin : main
		reset           = 1'b1;
		inst_sram_rdata = '0;
		data_sram_rdata = '0;
		loaded          = 1'b0;
		load_input();
		if (!input_ok) begin
			$display("sim/cpu_input.txt is missing or its counts are out of range");
			$display("Test failed");
			$finish;
		end else begin
			void'($urandom(66));
			for (int i = 0; i < mem_words; i++)
				dmem[i] = $urandom; // unused data words get noise
			loaded = 1'b1;
			repeat (3) @(posedge clk);
			#1 reset = 1'b0;
			wait (seen == n_exp);
			wait_past_program(reset_pc + 32'(4 * (n_prog + 8)));
			print_counts(0);
			if (mismatches + extra + DUT.u_assertions.fails == 0)
				$display("Test completed successfully");
			else
				$display("Test failed");
			$finish;
		end
	end

endmodule

`default_nettype wire

//--- sim/cpu_input.txt
// line 1: program word count, expected trace entry count (hex)
// then program words from reset_pc, then one trace entry per line: pc  register  value
0000001e 00000014
02801401 02801c02 00100823 00110464 00100c85 001004a6
001110c7 142468a8 0299e108 02bffc09 0010250a 0284000b
29800168 2980116a 2880016c 0010258d 2880116e 001131cf
58000d4e 02800410 02800810 5c000c82 02800c10 02801211
50000c00 02802412 02802812 02819020 00100413 00104234
1c000000 01 00000005
1c000004 02 00000007
1c000008 03 0000000c
1c00000c 04 00000007
1c000010 05 00000013
1c000014 06 00000018
1c000018 07 00000011
1c00001c 08 12345000
1c000020 08 12345678
1c000024 09 ffffffff
1c000028 0a 12345677
1c00002c 0b 00000100
1c000038 0c 12345678
1c00003c 0d 12345677
1c000040 0e 12345677
1c000044 0f ffffffff
1c000058 10 00000003
1c00005c 11 00000007
1c000070 13 00000005
1c000074 14 0000000a

//--- list.f
design/cpu_pkg.sv
design/pipe_ctrl.sv
design/fetch_stage.sv
design/decode_stage.sv
design/execute_stage.sv
design/mem_wb_stage.sv
design/cpu_top.sv
sim/tb_assertions.sv
sim/tb_checker.sv
sim/tb_top.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the pipeline testbench with Verilator
set -eo pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module tb_top -f list.f -o sim_tb
./obj_dir/sim_tb | tee sim.log

if grep -q "Test failed" sim.log || ! grep -q "Test completed successfully" sim.log; then
	echo "simulation reported failure"
	exit 1
fi
echo "simulation passed"
